// ==== sim.f ====
hw/rv_decode_pkg.sv
hw/rv_format_stage.sv
hw/rv_imm_gen.sv
hw/rv_op_decode.sv
hw/rv_decode_stage.sv
hw/rv_decode_top.sv
verif/tb_rv_decode.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
TOP       ?= tb_rv_decode
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

// ==== verif/tb_rv_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_decode import rv_decode_pkg::*; ();

  localparam int RESET_CYCLES = 8;
  localparam int LATENCY      = 2;   // Req cycle to done cycle
  localparam int TIMEOUT      = 400;
  localparam int DRAIN_CYCLES = 6;

  logic      clk;
  logic      rst;
  logic      req;
  word_t     inst;
  logic      done;
  op_e       op;
  fmt_e      fmt;
  logic      illegal;
  reg_addr_t rd;
  reg_addr_t rs1;
  reg_addr_t rs2;
  funct3_t   funct3;
  reg_addr_t shamt;
  word_t     imm;

  // Stimulus and expected results, one entry per row
  word_t     t_inst[$];
  op_e       t_op[$];
  fmt_e      t_fmt[$];
  logic      t_ill[$];
  reg_addr_t t_rd[$];
  reg_addr_t t_rs1[$];
  reg_addr_t t_rs2[$];
  funct3_t   t_f3[$];
  reg_addr_t t_sh[$];
  word_t     t_imm[$];

  int     issue_q[$];  // Cycle in which each req is driven
  int     cyc = 0;
  int     n_checked = 0;
  int     exp_cycle;
  integer seed;

  rv_decode_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .req     (req),
    .inst    (inst),
    .done    (done),
    .op      (op),
    .fmt     (fmt),
    .illegal (illegal),
    .rd      (rd),
    .rs1     (rs1),
    .rs2     (rs2),
    .funct3  (funct3),
    .shamt   (shamt),
    .imm     (imm)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR %s got 0x%08h exp 0x%08h", name, got, exp);
      $display("Errors found");
      $fatal(1, "decoder output mismatch");
    end
  endtask

  task automatic add_row(input word_t i, input op_e o, input fmt_e f, input reg_addr_t d,
                         input reg_addr_t s1, input reg_addr_t s2, input funct3_t f3,
                         input reg_addr_t sh, input word_t im);
    t_inst.push_back(i);
    t_op.push_back(o);
    t_fmt.push_back(f);
    t_ill.push_back(o == OP_ILLEGAL);
    t_rd.push_back(d);
    t_rs1.push_back(s1);
    t_rs2.push_back(s2);
    t_f3.push_back(f3);
    t_sh.push_back(sh);
    t_imm.push_back(im);
  endtask

  // Encoders build the word from the same fields the row expects back
  task automatic r_type_row(input op_e o, input logic [6:0] f7, input funct3_t f3,
                            input reg_addr_t d, input reg_addr_t s1, input reg_addr_t s2);
    add_row({f7, s2, s1, f3, d, OPC_OP}, o, FMT_R, d, s1, s2, f3, 5'd0, 32'h0);
  endtask

  task automatic i_type_row(input op_e o, input logic [6:0] opc, input funct3_t f3,
                            input reg_addr_t d, input reg_addr_t s1, input word_t im);
    add_row({im[11:0], s1, f3, d, opc}, o, FMT_I, d, s1, 5'd0, f3, 5'd0, im);
  endtask

  task automatic shift_row(input op_e o, input logic [6:0] f7, input funct3_t f3,
                           input reg_addr_t d, input reg_addr_t s1, input reg_addr_t sh);
    add_row({f7, sh, s1, f3, d, OPC_OP_IMM}, o, FMT_I, d, s1, 5'd0, f3, sh, {20'b0, f7, sh});
  endtask

  task automatic store_row(input op_e o, input funct3_t f3, input reg_addr_t s1,
                           input reg_addr_t s2, input word_t im);
    add_row({im[11:5], s2, s1, f3, im[4:0], OPC_STORE}, o, FMT_S, 5'd0, s1, s2, f3, 5'd0, im);
  endtask

  task automatic branch_row(input op_e o, input funct3_t f3, input reg_addr_t s1,
                            input reg_addr_t s2, input word_t im);
    add_row({im[12], im[10:5], s2, s1, f3, im[4:1], im[11], OPC_BRANCH},
            o, FMT_B, 5'd0, s1, s2, f3, 5'd0, im);
  endtask

  task automatic upper_row(input op_e o, input logic [6:0] opc, input reg_addr_t d,
                           input word_t im);
    add_row({im[31:12], d, opc}, o, FMT_U, d, 5'd0, 5'd0, 3'd0, 5'd0, im);
  endtask

  task automatic jal_row(input reg_addr_t d, input word_t im);
    add_row({im[20], im[10:1], im[11], im[19:12], d, OPC_JAL},
            OP_JAL, FMT_J, d, 5'd0, 5'd0, 3'd0, 5'd0, im);
  endtask

  task automatic build_table();
    upper_row(OP_LUI, OPC_LUI, 5'd1, 32'h1234_5000);
    upper_row(OP_LUI, OPC_LUI, 5'd2, 32'hffff_f000);
    upper_row(OP_AUIPC, OPC_AUIPC, 5'd3, 32'h8000_0000);
    upper_row(OP_AUIPC, OPC_AUIPC, 5'd4, 32'h0000_1000);
    jal_row(5'd1, 32'h0000_0800);
    jal_row(5'd0, 32'hfff0_0000);
    jal_row(5'd5, 32'h000f_fffe);
    jal_row(5'd6, 32'hffff_fffe);
    i_type_row(OP_JALR, OPC_JALR, 3'd0, 5'd1, 5'd2, 32'h0000_0010);
    i_type_row(OP_JALR, OPC_JALR, 3'd0, 5'd5, 5'd6, 32'hffff_fffc);
    branch_row(OP_BEQ, 3'd0, 5'd1, 5'd2, 32'h0000_0010);
    branch_row(OP_BNE, 3'd1, 5'd3, 5'd4, 32'hffff_fffe);
    branch_row(OP_BLT, 3'd4, 5'd5, 5'd6, 32'h0000_0ffe);
    branch_row(OP_BGE, 3'd5, 5'd7, 5'd8, 32'hffff_f000);
    branch_row(OP_BLTU, 3'd6, 5'd9, 5'd10, 32'h0000_0800);
    branch_row(OP_BGEU, 3'd7, 5'd11, 5'd12, 32'hffff_f7fe);
    i_type_row(OP_LB, OPC_LOAD, 3'd0, 5'd3, 5'd4, 32'h0000_07ff);
    i_type_row(OP_LH, OPC_LOAD, 3'd1, 5'd7, 5'd8, 32'hffff_f800);
    i_type_row(OP_LW, OPC_LOAD, 3'd2, 5'd9, 5'd10, 32'h0000_0004);
    i_type_row(OP_LBU, OPC_LOAD, 3'd4, 5'd11, 5'd12, 32'hffff_ffff);
    i_type_row(OP_LHU, OPC_LOAD, 3'd5, 5'd13, 5'd14, 32'h0000_0123);
    store_row(OP_SB, 3'd0, 5'd1, 5'd2, 32'h0000_0020);
    store_row(OP_SH, 3'd1, 5'd3, 5'd4, 32'hffff_f800);
    store_row(OP_SW, 3'd2, 5'd5, 5'd6, 32'h0000_07ff);
    i_type_row(OP_ADDI, OPC_OP_IMM, 3'd0, 5'd1, 5'd31, 32'hffff_fffb);
    i_type_row(OP_SLTI, OPC_OP_IMM, 3'd2, 5'd15, 5'd16, 32'h0000_0055);
    i_type_row(OP_SLTIU, OPC_OP_IMM, 3'd3, 5'd17, 5'd18, 32'hffff_f9aa);
    i_type_row(OP_XORI, OPC_OP_IMM, 3'd4, 5'd19, 5'd20, 32'hffff_ffff);
    i_type_row(OP_ORI, OPC_OP_IMM, 3'd6, 5'd21, 5'd22, 32'h0000_0700);
    i_type_row(OP_ANDI, OPC_OP_IMM, 3'd7, 5'd23, 5'd24, 32'h0000_00ff);
    shift_row(OP_SLLI, F7_BASE, 3'd1, 5'd1, 5'd2, 5'd31);
    shift_row(OP_SRLI, F7_BASE, 3'd5, 5'd3, 5'd4, 5'd7);
    shift_row(OP_SRAI, F7_ALT, 3'd5, 5'd5, 5'd6, 5'd1);
    r_type_row(OP_ADD, F7_BASE, 3'd0, 5'd1, 5'd2, 5'd3);
    r_type_row(OP_SUB, F7_ALT, 3'd0, 5'd4, 5'd5, 5'd6);
    r_type_row(OP_SLL, F7_BASE, 3'd1, 5'd7, 5'd8, 5'd9);
    r_type_row(OP_SLT, F7_BASE, 3'd2, 5'd10, 5'd11, 5'd12);
    r_type_row(OP_SLTU, F7_BASE, 3'd3, 5'd13, 5'd14, 5'd15);
    r_type_row(OP_XOR, F7_BASE, 3'd4, 5'd16, 5'd17, 5'd18);
    r_type_row(OP_SRL, F7_BASE, 3'd5, 5'd19, 5'd20, 5'd21);
    r_type_row(OP_SRA, F7_ALT, 3'd5, 5'd22, 5'd23, 5'd24);
    r_type_row(OP_OR, F7_BASE, 3'd6, 5'd25, 5'd26, 5'd27);
    r_type_row(OP_AND, F7_BASE, 3'd7, 5'd28, 5'd29, 5'd30);
    i_type_row(OP_FENCE, OPC_MISC_MEM, 3'd0, 5'd0, 5'd0, 32'h0000_00ff);
    i_type_row(OP_ECALL, OPC_SYSTEM, 3'd0, 5'd0, 5'd0, 32'h0000_0000);
    i_type_row(OP_EBREAK, OPC_SYSTEM, 3'd0, 5'd0, 5'd0, 32'h0000_0001);
    // Illegal words, fields still follow the format
    add_row(32'hdead_be77, OP_ILLEGAL, FMT_NONE, 5'd0, 5'd0, 5'd0, 3'd0, 5'd0, 32'h0);
    add_row(32'h0000_0000, OP_ILLEGAL, FMT_NONE, 5'd0, 5'd0, 5'd0, 3'd0, 5'd0, 32'h0);
    r_type_row(OP_ILLEGAL, 7'b0000001, 3'd0, 5'd1, 5'd2, 5'd3);
    r_type_row(OP_ILLEGAL, F7_ALT, 3'd7, 5'd4, 5'd5, 5'd6);
    i_type_row(OP_ILLEGAL, OPC_LOAD, 3'd3, 5'd4, 5'd5, 32'h0000_0010);
    i_type_row(OP_ILLEGAL, OPC_LOAD, 3'd6, 5'd6, 5'd7, 32'hffff_ff00);
    i_type_row(OP_ILLEGAL, OPC_JALR, 3'd1, 5'd1, 5'd1, 32'h0000_0000);
    i_type_row(OP_ILLEGAL, OPC_SYSTEM, 3'd0, 5'd3, 5'd0, 32'h0000_0000);
    i_type_row(OP_ILLEGAL, OPC_SYSTEM, 3'd0, 5'd0, 5'd0, 32'h0000_0002);
    i_type_row(OP_ILLEGAL, OPC_SYSTEM, 3'd1, 5'd1, 5'd2, 32'h0000_0300);
    i_type_row(OP_ILLEGAL, OPC_MISC_MEM, 3'd1, 5'd0, 5'd0, 32'h0000_0000);
    store_row(OP_ILLEGAL, 3'd3, 5'd1, 5'd2, 32'h0000_0004);
    branch_row(OP_ILLEGAL, 3'd2, 5'd1, 5'd2, 32'h0000_0008);
  endtask

  // Results are compared at the falling edge, in issue order
  always @(negedge clk) begin
    if (!rst && done !== 1'b0 && done !== 1'b1) begin
      $display("done is unknown after reset");
      $display("Errors found");
      $fatal(1, "unknown done");
    end
    if (done === 1'b1) begin
      if (issue_q.size() == 0 || n_checked >= t_inst.size()) begin
        $display("done pulse arrived with no request pending");
        $display("Errors found");
        $fatal(1, "unexpected done");
      end
      exp_cycle = issue_q.pop_front() + LATENCY;
      check_val("done_cycle", cyc, exp_cycle);
      check_val("op", 32'(op), 32'(t_op[n_checked]));
      check_val("fmt", 32'(fmt), 32'(t_fmt[n_checked]));
      check_val("illegal", 32'(illegal), 32'(t_ill[n_checked]));
      check_val("rd", 32'(rd), 32'(t_rd[n_checked]));
      check_val("rs1", 32'(rs1), 32'(t_rs1[n_checked]));
      check_val("rs2", 32'(rs2), 32'(t_rs2[n_checked]));
      check_val("funct3", 32'(funct3), 32'(t_f3[n_checked]));
      check_val("shamt", 32'(shamt), 32'(t_sh[n_checked]));
      check_val("imm", imm, t_imm[n_checked]);
      n_checked++;
    end
  end

  initial begin
    int gap;
    int wait_cnt;
    rst  = 1'b1;
    req  = 1'b0;
    inst = '0;
    seed = 32'h52efc4ad;
    build_table();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int i = 0; i < t_inst.size(); i++) begin
      gap = $unsigned($random(seed)) % 3; // Zero gives back-to-back issue
      for (int g = 0; g < gap; g++) begin
        @(posedge clk);
        #1;
        req = 1'b0;
      end
      @(posedge clk);
      #1;
      req  = 1'b1;
      inst = t_inst[i];
      issue_q.push_back(cyc);
    end
    @(posedge clk);
    #1;
    req = 1'b0;
    wait_cnt = 0;
    while (n_checked < t_inst.size() && wait_cnt < TIMEOUT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (n_checked < t_inst.size()) begin
      $display("timed out waiting for decoded results");
      $display("Errors found");
      $fatal(1, "result timeout");
    end
    // Idle tail so a stray extra pulse gets caught
    for (int k = 0; k < DRAIN_CYCLES; k++) begin
      @(posedge clk);
    end
    $display("No errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/rv_decode_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode_top import rv_decode_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  word_t     inst,
  output logic      done,
  output op_e       op,
  output fmt_e      fmt,
  output logic      illegal,
  output reg_addr_t rd,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output funct3_t   funct3,
  output reg_addr_t shamt,
  output word_t     imm
);

  logic  s1_valid;
  word_t s1_inst;
  fmt_e  s1_fmt;

  // Stage 1 captures and classifies
  rv_format_stage format_stage0 (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .inst     (inst),
    .s1_valid (s1_valid),
    .s1_inst  (s1_inst),
    .s1_fmt   (s1_fmt)
  );

  rv_decode_stage decode_stage0 (
    .clk      (clk),
    .rst      (rst),
    .s1_valid (s1_valid),
    .s1_inst  (s1_inst),
    .s1_fmt   (s1_fmt),
    .done     (done),
    .op       (op),
    .fmt      (fmt),
    .illegal  (illegal),
    .rd       (rd),
    .rs1      (rs1),
    .rs2      (rs2),
    .funct3   (funct3),
    .shamt    (shamt),
    .imm      (imm)
  );

endmodule

`default_nettype wire

// ==== hw/rv_decode_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decode_stage import rv_decode_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      s1_valid,
  input  word_t     s1_inst,
  input  fmt_e      s1_fmt,
  output logic      done,
  output op_e       op,
  output fmt_e      fmt,
  output logic      illegal,
  output reg_addr_t rd,
  output reg_addr_t rs1,
  output reg_addr_t rs2,
  output funct3_t   funct3,
  output reg_addr_t shamt,
  output word_t     imm
);

  word_t     imm_next;
  op_e       op_next;
  logic      illegal_next;
  logic      has_rd;
  logic      has_rs1;
  logic      has_rs2;
  reg_addr_t rd_next;
  reg_addr_t rs1_next;
  reg_addr_t rs2_next;
  reg_addr_t shamt_next;
  funct3_t   funct3_next;

  rv_imm_gen imm_gen0 (
    .s1_inst  (s1_inst),
    .s1_fmt   (s1_fmt),
    .imm_next (imm_next)
  );

  rv_op_decode op_decode0 (
    .s1_inst      (s1_inst),
    .s1_fmt       (s1_fmt),
    .op_next      (op_next),
    .illegal_next (illegal_next)
  );

  // Which register fields the format carries
  always_comb begin
    has_rd  = 1'b0;
    has_rs1 = 1'b0;
    has_rs2 = 1'b0;
    case (s1_fmt)
      FMT_R: begin
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
        has_rs2 = 1'b1;
      end
      FMT_I: begin
        has_rd  = 1'b1;
        has_rs1 = 1'b1;
      end
      FMT_S,
      FMT_B: begin
        has_rs1 = 1'b1;
        has_rs2 = 1'b1;
      end
      FMT_U,
      FMT_J: has_rd = 1'b1;
      default: ; // Unknown format keeps every field zero
    endcase
  end

  assign rd_next     = has_rd  ? s1_inst[11:7]  : '0;
  assign funct3_next = has_rs1 ? s1_inst[14:12] : '0; // funct3 travels with rs1
  assign rs1_next    = has_rs1 ? s1_inst[19:15] : '0;
  assign rs2_next    = has_rs2 ? s1_inst[24:20] : '0;
  assign shamt_next  = (op_next inside {OP_SLLI, OP_SRLI, OP_SRAI}) ? s1_inst[24:20] : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      done    <= 1'b0;
      op      <= OP_ILLEGAL;
      fmt     <= FMT_NONE;
      illegal <= 1'b0;
      rd      <= '0;
      rs1     <= '0;
      rs2     <= '0;
      funct3  <= '0;
      shamt   <= '0;
      imm     <= '0;
    end else begin
      done <= s1_valid;
      if (s1_valid) begin // Hold last result between pulses
        op      <= op_next;
        fmt     <= s1_fmt;
        illegal <= illegal_next;
        rd      <= rd_next;
        rs1     <= rs1_next;
        rs2     <= rs2_next;
        funct3  <= funct3_next;
        shamt   <= shamt_next;
        imm     <= imm_next;
      end
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_op_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_op_decode import rv_decode_pkg::*; (
  input  word_t s1_inst,
  input  fmt_e  s1_fmt,
  output op_e   op_next,
  output logic  illegal_next
);

  logic [6:0]  opcode;
  funct3_t     f3;
  logic [6:0]  f7;
  logic [11:0] imm12;
  reg_addr_t   rs1_idx;
  reg_addr_t   rd_idx;

  assign opcode  = s1_inst[6:0];
  assign rd_idx  = s1_inst[11:7];
  assign f3      = s1_inst[14:12];
  assign rs1_idx = s1_inst[19:15];
  assign imm12   = s1_inst[31:20];
  assign f7      = s1_inst[31:25];

  always_comb begin
    op_next = OP_ILLEGAL;
    case (s1_fmt)
      FMT_U: op_next = (opcode == OPC_LUI) ? OP_LUI : OP_AUIPC;
      FMT_J: op_next = OP_JAL;
      FMT_B: begin
        case (f3)
          3'b000:  op_next = OP_BEQ;
          3'b001:  op_next = OP_BNE;
          3'b100:  op_next = OP_BLT;
          3'b101:  op_next = OP_BGE;
          3'b110:  op_next = OP_BLTU;
          3'b111:  op_next = OP_BGEU;
          default: op_next = OP_ILLEGAL;
        endcase
      end
      FMT_S: begin
        case (f3)
          3'b000:  op_next = OP_SB;
          3'b001:  op_next = OP_SH;
          3'b010:  op_next = OP_SW;
          default: op_next = OP_ILLEGAL;
        endcase
      end
      FMT_R: begin
        if (f7 == F7_BASE) begin
          case (f3)
            F3_ADD:  op_next = OP_ADD;
            F3_SLL:  op_next = OP_SLL;
            F3_SLT:  op_next = OP_SLT;
            F3_SLTU: op_next = OP_SLTU;
            F3_XOR:  op_next = OP_XOR;
            F3_SR:   op_next = OP_SRL;
            F3_OR:   op_next = OP_OR;
            default: op_next = OP_AND;
          endcase
        end else if (f7 == F7_ALT) begin // Only SUB and SRA use the alternate funct7
          if (f3 == F3_ADD) begin
            op_next = OP_SUB;
          end else if (f3 == F3_SR) begin
            op_next = OP_SRA;
          end
        end
      end
      FMT_I: begin
        case (opcode)
          OPC_JALR: begin
            if (f3 == 3'b000) begin
              op_next = OP_JALR;
            end
          end
          OPC_LOAD: begin
            case (f3)
              3'b000:  op_next = OP_LB;
              3'b001:  op_next = OP_LH;
              3'b010:  op_next = OP_LW;
              3'b100:  op_next = OP_LBU;
              3'b101:  op_next = OP_LHU;
              default: op_next = OP_ILLEGAL;
            endcase
          end
          OPC_OP_IMM: begin
            case (f3)
              F3_ADD:  op_next = OP_ADDI;
              F3_SLT:  op_next = OP_SLTI;
              F3_SLTU: op_next = OP_SLTIU;
              F3_XOR:  op_next = OP_XORI;
              F3_OR:   op_next = OP_ORI;
              F3_AND:  op_next = OP_ANDI;
              F3_SLL:  op_next = (f7 == F7_BASE) ? OP_SLLI : OP_ILLEGAL;
              default: begin // Right shifts
                if (f7 == F7_BASE) begin
                  op_next = OP_SRLI;
                end else if (f7 == F7_ALT) begin
                  op_next = OP_SRAI;
                end
              end
            endcase
          end
          OPC_MISC_MEM: begin
            if (f3 == 3'b000) begin
              op_next = OP_FENCE;
            end
          end
          OPC_SYSTEM: begin
            if (f3 == 3'b000 && rs1_idx == '0 && rd_idx == '0) begin
              if (imm12 == SYS_ECALL) begin
                op_next = OP_ECALL;
              end else if (imm12 == SYS_EBREAK) begin
                op_next = OP_EBREAK;
              end
            end
          end
          default: op_next = OP_ILLEGAL;
        endcase
      end
      default: op_next = OP_ILLEGAL; // Unknown opcode
    endcase
  end

  assign illegal_next = (op_next == OP_ILLEGAL);

endmodule

`default_nettype wire

// ==== hw/rv_imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_imm_gen import rv_decode_pkg::*; (
  input  word_t s1_inst,
  input  fmt_e  s1_fmt,
  output word_t imm_next
);

  logic sign;

  assign sign = s1_inst[INST_W-1];

  always_comb begin
    case (s1_fmt)
      FMT_I: imm_next = {{(XLEN-12){sign}}, s1_inst[31:20]};
      FMT_S: imm_next = {{(XLEN-12){sign}}, s1_inst[31:25], s1_inst[11:7]};
      FMT_B: begin // Offset in halfwords
        imm_next = {{(XLEN-13){sign}}, s1_inst[31], s1_inst[7],
                    s1_inst[30:25], s1_inst[11:8], 1'b0};
      end
      FMT_U: imm_next = {s1_inst[31:12], 12'b0};
      FMT_J: begin
        imm_next = {{(XLEN-21){sign}}, s1_inst[31], s1_inst[19:12],
                    s1_inst[20], s1_inst[30:21], 1'b0};
      end
      default: imm_next = '0; // R and unknown formats
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rv_format_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_format_stage import rv_decode_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  req,
  input  word_t inst,
  output logic  s1_valid,
  output word_t s1_inst,
  output fmt_e  s1_fmt
);

  fmt_e fmt_next;

  always_comb begin
    case (inst[6:0])
      OPC_OP:       fmt_next = FMT_R;
      OPC_JALR,
      OPC_LOAD,
      OPC_OP_IMM,
      OPC_MISC_MEM,
      OPC_SYSTEM:   fmt_next = FMT_I;
      OPC_STORE:    fmt_next = FMT_S;
      OPC_BRANCH:   fmt_next = FMT_B;
      OPC_LUI,
      OPC_AUIPC:    fmt_next = FMT_U;
      OPC_JAL:      fmt_next = FMT_J;
      default:      fmt_next = FMT_NONE; // Unknown opcode
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_fmt   <= FMT_NONE;
    end else begin
      s1_valid <= req;
      if (req) begin
        s1_fmt <= fmt_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      s1_inst <= inst;
    end
  end

endmodule

`default_nettype wire

// ==== hw/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

  localparam int INST_W     = 32;
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  typedef logic [INST_W-1:0]     word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [2:0]            funct3_t;

  // Major opcodes, inst[6:0]
  localparam logic [6:0] OPC_LUI      = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
  localparam logic [6:0] OPC_JAL      = 7'b1101111;
  localparam logic [6:0] OPC_JALR     = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
  localparam logic [6:0] OPC_LOAD     = 7'b0000011;
  localparam logic [6:0] OPC_STORE    = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_OP       = 7'b0110011;
  localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI

  // funct3 codes shared by OP and OP_IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // imm[11:0] of the two SYSTEM instructions
  localparam logic [11:0] SYS_ECALL  = 12'h000;
  localparam logic [11:0] SYS_EBREAK = 12'h001;

  typedef enum logic [2:0] {
    FMT_NONE,
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J
  } fmt_e;

  typedef enum logic [5:0] {
    OP_ILLEGAL,
    // Upper immediate and jumps
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    // Branches
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    // Loads and stores
    OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
    OP_SB, OP_SH, OP_SW,
    // Register-immediate
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
    OP_SLLI, OP_SRLI, OP_SRAI,
    // Register-register
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    // Fence and system
    OP_FENCE, OP_ECALL, OP_EBREAK
  } op_e;

endpackage

`default_nettype wire
